/* design/gpio_core.sv */
// GPIO register core
// Output and enable registers, edge masks, sticky interrupt status
// Input synchronizer instance, edge detection and read multiplexer

`timescale 1ns/100ps

module gpio_core #(
    parameter int unsigned GDW = 32,
    parameter int unsigned CDC = 2
) (
    input  logic                clk,
    input  logic                reset,
    // Register access from the bus adapter
    input  logic                reg_en,
    input  gpio_pkg::tcb_op_e   reg_op,
    input  gpio_pkg::gpio_reg_e reg_sel,
    input  logic [GDW-1:0]      reg_wdt,
    output logic [GDW-1:0]      reg_rdt,
    // Pins
    output logic [GDW-1:0]      gpio_out,
    output logic [GDW-1:0]      gpio_oe,
    input  logic [GDW-1:0]      gpio_in,
    // Interrupt request
    output logic                irq
);

    import gpio_pkg::*;

    // Write strobe, only mapped accesses reach here
    logic           reg_wr;
    // Synchronized pins and their previous sample
    logic [GDW-1:0] in_sync;
    logic [GDW-1:0] in_prev;
    // Edge masks
    logic [GDW-1:0] rise_en;
    logic [GDW-1:0] fall_en;
    // Raw and masked edge events
    logic [GDW-1:0] rise_evt;
    logic [GDW-1:0] fall_evt;
    logic [GDW-1:0] edge_set;
    // Status bits and their clear mask
    logic [GDW-1:0] irq_sts;
    logic [GDW-1:0] sts_clr;

    assign reg_wr = reg_en && (reg_op == TCB_WRITE);

    ////////////////////////////////////////////////////////////////////////////
    // Input path
    ////////////////////////////////////////////////////////////////////////////

    gpio_input_sync #(
        .GDW    (GDW),
        .STAGES (CDC)
    ) u_sync (
        .clk       (clk),
        .reset     (reset),
        .pin_async (gpio_in),
        .pin_sync  (in_sync)
    );

    // Previous sample for edge compare
    always_ff @(posedge clk) begin
        if (reset) begin
            in_prev <= '0;
        end else begin
            in_prev <= in_sync;
        end
    end

    // Low to high and high to low per pin
    assign rise_evt = in_sync & ~in_prev;
    assign fall_evt = ~in_sync & in_prev;
    assign edge_set = (rise_evt & rise_en) | (fall_evt & fall_en);

    ////////////////////////////////////////////////////////////////////////////
    // Writable registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_out <= '0;
            gpio_oe  <= '0;
            rise_en  <= '0;
            fall_en  <= '0;
        end else if (reg_wr) begin
            case (reg_sel)
                REG_OUT:     gpio_out <= reg_wdt;
                REG_OE:      gpio_oe  <= reg_wdt;
                REG_RISE_EN: rise_en  <= reg_wdt;
                REG_FALL_EN: fall_en  <= reg_wdt;
                // Status handled below, REG_IN is read only
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt status
    ////////////////////////////////////////////////////////////////////////////

    // Ones written to the status word clear those bits
    assign sts_clr = (reg_wr && (reg_sel == REG_IRQ_STS)) ? reg_wdt : '0;

    // Set term applied last so a fresh edge beats a clear
    always_ff @(posedge clk) begin
        if (reset) begin
            irq_sts <= '0;
        end else begin
            irq_sts <= (irq_sts & ~sts_clr) | edge_set;
        end
    end

    // Registered request, one cycle behind the status
    always_ff @(posedge clk) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= |irq_sts;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read multiplexer
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (reg_sel)
            REG_OUT:     reg_rdt = gpio_out;
            REG_OE:      reg_rdt = gpio_oe;
            REG_IN:      reg_rdt = in_sync;
            REG_RISE_EN: reg_rdt = rise_en;
            REG_FALL_EN: reg_rdt = fall_en;
            REG_IRQ_STS: reg_rdt = irq_sts;
            // Unmapped indices read as zero
            default:     reg_rdt = '0;
        endcase
    end

endmodule

/* design/gpio_input_sync.sv */
// Flip-flop synchronizer for the GPIO input pins
// Depth set by STAGES, zero gives a straight bypass

`timescale 1ns/100ps

module gpio_input_sync #(
    parameter int unsigned GDW    = 32,
    parameter int unsigned STAGES = 2
) (
    input  logic           clk,
    input  logic           reset,
    input  logic [GDW-1:0] pin_async,
    output logic [GDW-1:0] pin_sync
);

    generate
        if (STAGES == 0) begin : g_bypass
            // Pins already in the clk domain
            assign pin_sync = pin_async;
        end else begin : g_chain
            // One rank per stage, rank 0 samples the pins
            logic [STAGES-1:0][GDW-1:0] ranks;

            always_ff @(posedge clk) begin
                if (reset) begin
                    ranks <= '0;
                end else begin
                    ranks[0] <= pin_async;
                    for (int i = 1; i < STAGES; i++) begin
                        ranks[i] <= ranks[i-1];
                    end
                end
            end

            // Last rank is the stable copy
            assign pin_sync = ranks[STAGES-1];
        end
    endgenerate

endmodule

/* design/gpio_pkg.sv */
// Shared types for the GPIO subsystem
// Register select and bus operation encodings

package gpio_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    // Word index within the peripheral window
    // Indices 6 and 7 are not mapped
    typedef enum logic [2:0] {
        REG_OUT     = 3'd0,
        REG_OE      = 3'd1,
        REG_IN      = 3'd2,
        REG_RISE_EN = 3'd3,
        REG_FALL_EN = 3'd4,
        REG_IRQ_STS = 3'd5
    } gpio_reg_e;

    // Direction of a bus transfer
    typedef enum logic {
        TCB_READ  = 1'b0,
        TCB_WRITE = 1'b1
    } tcb_op_e;

endpackage

/* design/gpio_subsystem_top.sv */
// GPIO subsystem top level
// TCB-Lite adapter and GPIO core wired to bus and pin ports

`timescale 1ns/100ps

`include "gpio_defs.svh"

module gpio_subsystem_top (
    input  logic                 clk,
    input  logic                 reset,
    // TCB-Lite bus
    input  logic                 tcb_vld,
    input  logic                 tcb_wen,
    input  logic [`TCB_AW-1:0]   tcb_adr,
    input  logic [`TCB_DW-1:0]   tcb_wdt,
    output logic                 tcb_ready,
    output logic [`TCB_DW-1:0]   tcb_rdt,
    output logic                 tcb_err,
    // Pins
    output logic [`GPIO_GDW-1:0] gpio_out,
    output logic [`GPIO_GDW-1:0] gpio_oe,
    input  logic [`GPIO_GDW-1:0] gpio_in,
    output logic                 irq
);

    import gpio_pkg::*;

    // Adapter to core register access
    logic               reg_en;
    tcb_op_e            reg_op;
    gpio_reg_e          reg_sel;
    logic [`TCB_DW-1:0] reg_wdt;
    logic [`TCB_DW-1:0] reg_rdt;

    tcb_lite_gpio u_adapter (
        .clk       (clk),
        .reset     (reset),
        .tcb_vld   (tcb_vld),
        .tcb_wen   (tcb_wen),
        .tcb_adr   (tcb_adr),
        .tcb_wdt   (tcb_wdt),
        .tcb_ready (tcb_ready),
        .tcb_rdt   (tcb_rdt),
        .tcb_err   (tcb_err),
        .reg_en    (reg_en),
        .reg_op    (reg_op),
        .reg_sel   (reg_sel),
        .reg_wdt   (reg_wdt),
        .reg_rdt   (reg_rdt)
    );

    gpio_core #(
        .GDW (`GPIO_GDW),
        .CDC (`GPIO_CDC)
    ) u_core (
        .clk      (clk),
        .reset    (reset),
        .reg_en   (reg_en),
        .reg_op   (reg_op),
        .reg_sel  (reg_sel),
        .reg_wdt  (reg_wdt),
        .reg_rdt  (reg_rdt),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe),
        .gpio_in  (gpio_in),
        .irq      (irq)
    );

endmodule

/* design/tcb_lite_gpio.sv */
// TCB-Lite subordinate adapter for the GPIO core
// Address decode, read/write split, error flag and read data return

`timescale 1ns/100ps

`include "gpio_defs.svh"

module tcb_lite_gpio (
    input  logic                clk,
    input  logic                reset,
    // TCB-Lite subordinate side
    input  logic                tcb_vld,
    input  logic                tcb_wen,
    input  logic [`TCB_AW-1:0]  tcb_adr,
    input  logic [`TCB_DW-1:0]  tcb_wdt,
    output logic                tcb_ready,
    output logic [`TCB_DW-1:0]  tcb_rdt,
    output logic                tcb_err,
    // Register access toward the core
    output logic                reg_en,
    output gpio_pkg::tcb_op_e   reg_op,
    output gpio_pkg::gpio_reg_e reg_sel,
    output logic [`TCB_DW-1:0]  reg_wdt,
    input  logic [`TCB_DW-1:0]  reg_rdt
);

    import gpio_pkg::*;

    // Transfer in this cycle
    logic trn;
    // Word index hits a register
    logic adr_ok;
    // Write aimed at the input register
    logic ro_hit;

    // No back-pressure, every request completes at once
    assign tcb_ready = 1'b1;
    assign trn       = tcb_vld & tcb_ready;

    // Word index from byte address bits 4 to 2
    assign reg_sel = gpio_reg_e'(tcb_adr[`TCB_AW-1 -: 3]);
    assign reg_op  = tcb_wen ? TCB_WRITE : TCB_READ;
    assign reg_wdt = tcb_wdt;

    // Only six of eight indices are decoded
    assign adr_ok = reg_sel inside {REG_OUT, REG_OE, REG_IN,
                                    REG_RISE_EN, REG_FALL_EN, REG_IRQ_STS};
    assign ro_hit = tcb_wen && (reg_sel == REG_IN);

    // Error response, core access suppressed
    assign tcb_err = trn & (~adr_ok | ro_hit);
    assign reg_en  = trn & ~tcb_err;

    // Zero-delay response, zero data on error
    assign tcb_rdt = tcb_err ? '0 : reg_rdt;

endmodule

/* include/gpio_defs.svh */
// Build-time sizes for the GPIO subsystem
// Pin count, input synchronizer depth and bus widths

`ifndef GPIO_DEFS_SVH
`define GPIO_DEFS_SVH

// Number of GPIO pins
`define GPIO_GDW 32

// Input synchronizer ranks, 0 bypasses the chain
`define GPIO_CDC 2

// Bus data width in bits
`define TCB_DW 32

// Bus byte address width, enough for eight word registers
`define TCB_AW 5

`endif

/* project.f */
+incdir+include
design/gpio_pkg.sv
design/gpio_input_sync.sv
design/gpio_core.sv
design/tcb_lite_gpio.sv
design/gpio_subsystem_top.sv
test/gpio_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the GPIO subsystem testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=gpio_sim

verilator --binary --timing --assert --top-module gpio_tb -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "RESULT: PASS" "$LOG"; then
    echo "No result line found in $LOG"
    exit 1
fi
exit 0

/* test/gpio_tb.sv */
// Testbench for the GPIO subsystem
// Clock, reset, TCB-Lite driver tasks, pin stimulus
// Reference model of registers and edge status, concurrent and immediate checks

`timescale 1ns/100ps

`include "gpio_defs.svh"

module gpio_tb;

    import gpio_pkg::*;

    localparam int GDW          = `GPIO_GDW;
    localparam int XFER_TIMEOUT = 16;
    localparam int IRQ_TIMEOUT  = 16;

    logic                 clk;
    logic                 reset;
    logic                 tcb_vld;
    logic                 tcb_wen;
    logic [`TCB_AW-1:0]   tcb_adr;
    logic [`TCB_DW-1:0]   tcb_wdt;
    logic                 tcb_ready;
    logic [`TCB_DW-1:0]   tcb_rdt;
    logic                 tcb_err;
    logic [GDW-1:0]       gpio_out;
    logic [GDW-1:0]       gpio_oe;
    logic [GDW-1:0]       gpio_in;
    logic                 irq;

    // Failure counters, one per source
    int chk_errs;
    int seq_errs;
    int timeouts;

    gpio_subsystem_top UUT (
        .clk       (clk),
        .reset     (reset),
        .tcb_vld   (tcb_vld),
        .tcb_wen   (tcb_wen),
        .tcb_adr   (tcb_adr),
        .tcb_wdt   (tcb_wdt),
        .tcb_ready (tcb_ready),
        .tcb_rdt   (tcb_rdt),
        .tcb_err   (tcb_err),
        .gpio_out  (gpio_out),
        .gpio_oe   (gpio_oe),
        .gpio_in   (gpio_in),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    logic [2:0]           idx;
    logic                 exp_err;
    logic [`TCB_DW-1:0]   exp_rdt;
    logic [GDW-1:0]       exp_out;
    logic [GDW-1:0]       exp_oe;
    logic [GDW-1:0]       exp_rise;
    logic [GDW-1:0]       exp_fall;
    logic [GDW-1:0]       exp_sts;
    logic                 exp_irq;
    logic [GDW-1:0]       exp_prev;
    logic [GDW-1:0]       exp_sync;
    logic [GDW-1:0]       exp_edge;
    logic [GDW-1:0]       wr_clr;
    // Pin history, entry k holds gpio_in from k+1 edges back
    logic [GDW-1:0]       in_hist [0:`GPIO_CDC];

    assign idx      = tcb_adr[`TCB_AW-1 -: 3];
    // Indices 6 and 7 unmapped, REG_IN read only
    assign exp_err  = tcb_vld && ((idx > 3'd5) || (tcb_wen && idx == REG_IN));
    assign exp_sync = (`GPIO_CDC == 0) ? gpio_in : in_hist[`GPIO_CDC-1];
    // Oldest entry is the synchronized value one edge back
    assign exp_prev = in_hist[`GPIO_CDC];
    assign exp_edge = (exp_sync & ~exp_prev & exp_rise) | (~exp_sync & exp_prev & exp_fall);
    assign wr_clr   = (tcb_vld && tcb_wen && !exp_err && idx == REG_IRQ_STS) ? tcb_wdt : '0;

    // Expected read data for the current request
    always_comb begin
        case (idx)
            REG_OUT:     exp_rdt = exp_out;
            REG_OE:      exp_rdt = exp_oe;
            REG_IN:      exp_rdt = exp_sync;
            REG_RISE_EN: exp_rdt = exp_rise;
            REG_FALL_EN: exp_rdt = exp_fall;
            REG_IRQ_STS: exp_rdt = exp_sts;
            default:     exp_rdt = '0;
        endcase
        if (exp_err) begin
            exp_rdt = '0;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            exp_out  <= '0;
            exp_oe   <= '0;
            exp_rise <= '0;
            exp_fall <= '0;
            exp_sts  <= '0;
            exp_irq  <= 1'b0;
            for (int i = 0; i <= `GPIO_CDC; i++) begin
                in_hist[i] <= '0;
            end
        end else begin
            in_hist[0] <= gpio_in;
            for (int i = 1; i <= `GPIO_CDC; i++) begin
                in_hist[i] <= in_hist[i-1];
            end
            // New edge wins over a clear in the same cycle
            exp_sts  <= (exp_sts & ~wr_clr) | exp_edge;
            exp_irq  <= |exp_sts;
            if (tcb_vld && tcb_wen && !exp_err) begin
                case (idx)
                    REG_OUT:     exp_out  <= tcb_wdt;
                    REG_OE:      exp_oe   <= tcb_wdt;
                    REG_RISE_EN: exp_rise <= tcb_wdt;
                    REG_FALL_EN: exp_fall <= tcb_wdt;
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Concurrent checks
    ////////////////////////////////////////////////////////////////////////////

    a_ready: assert property (@(posedge clk) tcb_ready)
        else begin
            chk_errs++;
            $display("FAIL %0t: tcb_ready low", $time);
        end

    a_err: assert property (@(posedge clk) disable iff (reset) tcb_err == exp_err)
        else begin
            chk_errs++;
            $display("FAIL %0t: tcb_err %0b, model %0b", $time, $sampled(tcb_err),
                     $sampled(exp_err));
        end

    // Error responses carry no data, reads or writes
    a_err_zero: assert property (@(posedge clk) disable iff (reset)
        tcb_err |-> tcb_rdt == '0)
        else begin
            chk_errs++;
            $display("FAIL %0t: nonzero read data on error", $time);
        end

    a_rdt: assert property (@(posedge clk) disable iff (reset)
        (tcb_vld && !tcb_wen) |-> tcb_rdt == exp_rdt)
        else begin
            chk_errs++;
            $display("FAIL %0t: read index %0d got %h, model %h", $time, $sampled(idx),
                     $sampled(tcb_rdt), $sampled(exp_rdt));
        end

    a_out: assert property (@(posedge clk) disable iff (reset) gpio_out == exp_out)
        else begin
            chk_errs++;
            $display("FAIL %0t: gpio_out %h, model %h", $time, $sampled(gpio_out),
                     $sampled(exp_out));
        end

    a_oe: assert property (@(posedge clk) disable iff (reset) gpio_oe == exp_oe)
        else begin
            chk_errs++;
            $display("FAIL %0t: gpio_oe %h, model %h", $time, $sampled(gpio_oe),
                     $sampled(exp_oe));
        end

    a_irq: assert property (@(posedge clk) disable iff (reset) irq == exp_irq)
        else begin
            chk_errs++;
            $display("FAIL %0t: irq %0b, model %0b", $time, $sampled(irq), $sampled(exp_irq));
        end

    ////////////////////////////////////////////////////////////////////////////
    // Bus and pin tasks
    ////////////////////////////////////////////////////////////////////////////

    // One TCB-Lite transfer, response sampled mid-cycle
    task automatic bus_xfer(input logic wen, input logic [2:0] sel,
                            input logic [`TCB_DW-1:0] wdt,
                            output logic [`TCB_DW-1:0] rdt, output logic err);
        int cycles;
        cycles = 0;
        @(posedge clk);
        tcb_vld <= 1'b1;
        tcb_wen <= wen;
        tcb_adr <= {sel, 2'b00};
        tcb_wdt <= wdt;
        @(negedge clk);
        while (!tcb_ready && cycles < XFER_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!tcb_ready) begin
            timeouts++;
            $display("Transfer to index %0d stalled, tcb_ready never went high", sel);
        end
        rdt = tcb_rdt;
        err = tcb_err;
        @(posedge clk);
        tcb_vld <= 1'b0;
        tcb_wen <= 1'b0;
    endtask

    task automatic write_reg(input logic [2:0] sel, input logic [`TCB_DW-1:0] val);
        logic [`TCB_DW-1:0] rdt;
        logic err;
        bus_xfer(1'b1, sel, val, rdt, err);
        assert (!err) else begin
            seq_errs++;
            $display("FAIL %0t: write to index %0d flagged an error", $time, sel);
        end
    endtask

    task automatic read_expect(input logic [2:0] sel, input logic [`TCB_DW-1:0] exp);
        logic [`TCB_DW-1:0] rdt;
        logic err;
        bus_xfer(1'b0, sel, '0, rdt, err);
        assert (!err && rdt == exp) else begin
            seq_errs++;
            $display("FAIL %0t: index %0d read %h err %0b, expected %h", $time, sel, rdt,
                     err, exp);
        end
    endtask

    // Unmapped or read-only access must be refused
    task automatic expect_bus_error(input logic wen, input logic [2:0] sel);
        logic [`TCB_DW-1:0] rdt;
        logic err;
        tcb_op_e op;
        op = wen ? TCB_WRITE : TCB_READ;
        bus_xfer(wen, sel, $urandom, rdt, err);
        $display("%0t: %s at index %0d, err %0b", $time, op.name(), sel, err);
        assert (err && rdt == '0) else begin
            seq_errs++;
            $display("FAIL %0t: %s at index %0d not refused", $time, op.name(), sel);
        end
    endtask

    // New pin value, then poll REG_IN until it follows
    task automatic drive_pins_and_settle(input logic [GDW-1:0] val);
        int cycles;
        logic [`TCB_DW-1:0] rdt;
        logic err;
        cycles = 0;
        @(posedge clk);
        gpio_in <= val;
        rdt = ~val;
        while (rdt != val && cycles < `GPIO_CDC + 2) begin
            bus_xfer(1'b0, REG_IN, '0, rdt, err);
            cycles += 2;
        end
        if (rdt != val) begin
            timeouts++;
            $display("REG_IN did not follow gpio_in within %0d cycles", cycles);
        end
    endtask

    task automatic wait_irq(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (irq != level && cycles < IRQ_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (irq != level) begin
            timeouts++;
            $display("irq did not reach %0b within %0d cycles", level, IRQ_TIMEOUT);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [GDW-1:0] val;
        logic [GDW-1:0] old_pins;
        logic [GDW-1:0] pins;
        logic [GDW-1:0] sts;
        logic [GDW-1:0] clr;
        logic [GDW-1:0] last_out;
        logic [GDW-1:0] last_oe;
        chk_errs = 0;
        seq_errs = 0;
        timeouts = 0;
        void'($urandom(32'ha14d));
        reset   <= 1'b1;
        tcb_vld <= 1'b0;
        tcb_wen <= 1'b0;
        tcb_adr <= '0;
        tcb_wdt <= '0;
        gpio_in <= '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        // Reset state
        @(negedge clk);
        assert (gpio_out == '0 && gpio_oe == '0 && !irq) else begin
            seq_errs++;
            $display("FAIL %0t: outputs not zero after reset", $time);
        end
        read_expect(REG_OUT, '0);
        read_expect(REG_OE, '0);
        read_expect(REG_RISE_EN, '0);
        read_expect(REG_FALL_EN, '0);
        read_expect(REG_IRQ_STS, '0);

        // Write and readback, pin outputs checked by the model
        last_out = '0;
        last_oe  = '0;
        for (int n = 0; n < 3; n++) begin
            last_out = $urandom;
            write_reg(REG_OUT, last_out);
            read_expect(REG_OUT, last_out);
            last_oe = $urandom;
            write_reg(REG_OE, last_oe);
            read_expect(REG_OE, last_oe);
            val = $urandom;
            write_reg(REG_RISE_EN, val);
            read_expect(REG_RISE_EN, val);
            val = $urandom;
            write_reg(REG_FALL_EN, val);
            read_expect(REG_FALL_EN, val);
        end

        // Input path with edges masked off
        write_reg(REG_RISE_EN, '0);
        write_reg(REG_FALL_EN, '0);
        for (int n = 0; n < 3; n++) begin
            pins = $urandom;
            drive_pins_and_settle(pins);
        end

        // Edge interrupts, bit 0 in both masks so some edge always hits
        write_reg(REG_IRQ_STS, '1);
        wait_irq(1'b0);
        write_reg(REG_RISE_EN, 32'h0F0F_00FF);
        write_reg(REG_FALL_EN, 32'h00FF_0F0F);
        old_pins = pins;
        pins = old_pins ^ ($urandom | 32'h1);
        drive_pins_and_settle(pins);
        wait_irq(1'b1);
        sts = (pins & ~old_pins & 32'h0F0F_00FF) | (~pins & old_pins & 32'h00FF_0F0F);
        read_expect(REG_IRQ_STS, sts);

        // Partial clear, then full clear drops irq
        clr = $urandom;
        write_reg(REG_IRQ_STS, clr);
        read_expect(REG_IRQ_STS, sts & ~clr);
        write_reg(REG_IRQ_STS, '1);
        wait_irq(1'b0);
        read_expect(REG_IRQ_STS, '0);

        // Bus errors leave every register alone
        expect_bus_error(1'b0, 3'd6);
        expect_bus_error(1'b0, 3'd7);
        expect_bus_error(1'b1, 3'd6);
        expect_bus_error(1'b1, 3'd7);
        expect_bus_error(1'b1, REG_IN);
        read_expect(REG_OUT, last_out);
        read_expect(REG_OE, last_oe);
        read_expect(REG_IN, pins);
        read_expect(REG_RISE_EN, 32'h0F0F_00FF);
        read_expect(REG_FALL_EN, 32'h00FF_0F0F);
        read_expect(REG_IRQ_STS, '0);

        repeat (2) @(posedge clk);
        $display("Errors: %0d assertion, %0d check, %0d timeout", chk_errs, seq_errs,
                 timeouts);
        if (chk_errs == 0 && seq_errs == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
